// File: hw/axi_uart_bridge_config.svh
`ifndef AXI_UART_BRIDGE_CONFIG_SVH
`define AXI_UART_BRIDGE_CONFIG_SVH

//////////////////////////////
// AXI widths
//////////////////////////////
`define AXI_ADDR_WIDTH 7
`define AXI_DATA_WIDTH 128
`define AXI_ID_WIDTH 16

//////////////////////////////
// Register map
//////////////////////////////
`define ADDR_UART_TX 7'h00      // Write only, low byte to UART
`define ADDR_CAM_CTRL 7'h10     // Write only, CC4..CC1
`define ADDR_UART_RX 7'h20      // Read only, blocks until a byte is held
`define ADDR_RX_VALID 7'h30     // Read only
`define ADDR_CLINK_READY 7'h40  // Read only

// Response codes
`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif

// File: hw/axi_uart_bridge_pkg.sv
`include "axi_uart_bridge_config.svh"

package axi_uart_bridge_pkg;

    //////////////////////////////
    // Bus and payload types
    //////////////////////////////
    typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;
    typedef logic [`AXI_ID_WIDTH-1:0] axi_id_t;
    typedef logic [1:0] axi_resp_t;
    typedef logic [7:0] uart_byte_t;
    typedef logic [3:0] cam_ctrl_t;  // Bit 0 is CC1

    //////////////////////////////
    // FSM states
    //////////////////////////////
    typedef enum logic [2:0] {
        WR_IDLE,      // Waiting on AW
        WR_UART,      // Beats go to the UART transmitter
        WR_CAM_CTRL,  // Beats update the camera-control bits
        WR_DRAIN,     // Bad address, beats discarded
        WR_RESP       // B channel pending
    } write_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,     // Waiting on AR
        RD_WAIT_RX,  // Byte requested but buffer empty
        RD_RESP      // R channel pending
    } read_state_t;

endpackage

// File: hw/uart_rx_buffer.sv
`timescale 1ns/1ps

module uart_rx_buffer
    import axi_uart_bridge_pkg::*;
(
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    input  logic       rx_ready,   // Strobe from the UART receiver
    input  uart_byte_t rx_data,
    input  logic       rx_clear,   // Byte consumed by a read
    output uart_byte_t rx_byte,
    output logic       rx_valid
);

    //////////////////////////////
    // One-byte holding register
    //////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rx_valid <= 1'b0;
        end else if (rx_clear) begin
            rx_valid <= 1'b0;  // Clear beats a same-cycle arrival
        end else if (rx_ready) begin
            rx_valid <= 1'b1;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (rx_ready && !rx_clear) begin
            rx_byte <= rx_data;  // Unread byte gets overwritten
        end
    end

endmodule

// File: hw/axi_write_ctrl.sv
`timescale 1ns/1ps
`include "axi_uart_bridge_config.svh"

module axi_write_ctrl
    import axi_uart_bridge_pkg::*;
(
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    // AW channel
    input  axi_addr_t  s_axi_awaddr,
    input  axi_id_t    s_axi_awid,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    // W channel
    input  axi_data_t  s_axi_wdata,
    input  logic       s_axi_wvalid,
    input  logic       s_axi_wlast,
    output logic       s_axi_wready,
    // B channel
    output axi_id_t    s_axi_bid,
    output axi_resp_t  s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    // UART transmitter and camera control
    output logic       tx_start,
    output uart_byte_t tx_data,
    input  logic       tx_busy,
    output cam_ctrl_t  cam_ctrl
);

    write_state_t state;
    axi_id_t      awid_q;   // ID echoed on B
    axi_resp_t    bresp_q;
    logic         aw_fire;
    logic         w_fire;
    logic         b_fire;

    //////////////////////////////
    // Handshakes
    //////////////////////////////
    assign aw_fire = s_axi_awvalid && s_axi_awready;
    assign w_fire  = s_axi_wvalid && s_axi_wready;
    assign b_fire  = s_axi_bvalid && s_axi_bready;

    assign s_axi_awready = (state == WR_IDLE);  // One write in flight at a time

    always_comb begin
        case (state)
            // Hold off while the pulse is out and until the UART reports busy
            WR_UART:               s_axi_wready = !tx_busy && !tx_start;
            WR_CAM_CTRL, WR_DRAIN: s_axi_wready = 1'b1;
            default:               s_axi_wready = 1'b0;
        endcase
    end

    assign s_axi_bvalid = (state == WR_RESP);  // Held until bready
    assign s_axi_bid    = awid_q;
    assign s_axi_bresp  = bresp_q;

    //////////////////////////////
    // Write FSM
    //////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        case (s_axi_awaddr)  // Decode target register
                            `ADDR_UART_TX:  state <= WR_UART;
                            `ADDR_CAM_CTRL: state <= WR_CAM_CTRL;
                            default:        state <= WR_DRAIN;
                        endcase
                    end
                end
                WR_UART, WR_CAM_CTRL, WR_DRAIN: begin
                    if (w_fire && s_axi_wlast) begin
                        state <= WR_RESP;  // Burst length comes from wlast only
                    end
                end
                WR_RESP: begin
                    if (b_fire) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Captured payload
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            awid_q <= s_axi_awid;
        end
        if (w_fire && s_axi_wlast) begin
            bresp_q <= (state == WR_DRAIN) ? `RESP_SLVERR : `RESP_OKAY;
        end
        if (w_fire && (state == WR_UART)) begin
            tx_data <= s_axi_wdata[7:0];  // Low byte of the beat
        end
    end

    //////////////////////////////
    // UART pulse and CC bits
    //////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            tx_start <= 1'b0;
            cam_ctrl <= '0;
        end else begin
            tx_start <= w_fire && (state == WR_UART);  // Single-cycle strobe per beat
            if (w_fire && (state == WR_CAM_CTRL)) begin
                cam_ctrl <= s_axi_wdata[3:0];  // Last beat wins
            end
        end
    end

endmodule

// File: hw/axi_read_ctrl.sv
`timescale 1ns/1ps
`include "axi_uart_bridge_config.svh"

module axi_read_ctrl
    import axi_uart_bridge_pkg::*;
(
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    // AR channel
    input  axi_addr_t  s_axi_araddr,
    input  axi_id_t    s_axi_arid,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    // R channel
    output axi_data_t  s_axi_rdata,
    output axi_id_t    s_axi_rid,
    output axi_resp_t  s_axi_rresp,
    output logic       s_axi_rvalid,
    output logic       s_axi_rlast,
    input  logic       s_axi_rready,
    // Receive buffer and camera status
    input  uart_byte_t rx_byte,
    input  logic       rx_valid,
    output logic       rx_clear,
    input  logic       clink_ready
);

    read_state_t state;
    axi_addr_t   araddr_q;
    axi_id_t     arid_q;
    axi_data_t   rdata_q;
    axi_resp_t   rresp_q;
    axi_data_t   sel_data;  // Value picked by the incoming address
    axi_resp_t   sel_resp;
    logic        ar_fire;
    logic        r_fire;

    assign ar_fire = s_axi_arvalid && s_axi_arready;
    assign r_fire  = s_axi_rvalid && s_axi_rready;

    assign s_axi_arready = (state == RD_IDLE);
    assign s_axi_rvalid  = (state == RD_RESP);
    assign s_axi_rlast   = s_axi_rvalid;  // Always single beat
    assign s_axi_rid     = arid_q;
    assign s_axi_rdata   = rdata_q;
    assign s_axi_rresp   = rresp_q;

    // Buffer empties once the byte has actually left on R
    assign rx_clear = r_fire && (araddr_q == `ADDR_UART_RX);

    //////////////////////////////
    // Register select
    //////////////////////////////
    always_comb begin
        sel_resp = `RESP_OKAY;
        case (s_axi_araddr)
            `ADDR_UART_RX:     sel_data = axi_data_t'(rx_byte);
            `ADDR_RX_VALID:    sel_data = axi_data_t'(rx_valid);
            `ADDR_CLINK_READY: sel_data = axi_data_t'(clink_ready);
            default: begin
                sel_data = '0;  // Unmapped
                sel_resp = `RESP_SLVERR;
            end
        endcase
    end

    //////////////////////////////
    // Read FSM
    //////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        if ((s_axi_araddr == `ADDR_UART_RX) && !rx_valid) begin
                            state <= RD_WAIT_RX;  // Nothing received yet
                        end else begin
                            state <= RD_RESP;
                        end
                    end
                end
                RD_WAIT_RX: begin
                    if (rx_valid) begin
                        state <= RD_RESP;
                    end
                end
                RD_RESP: begin
                    if (r_fire) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Response payload, frozen while rvalid is up
    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            araddr_q <= s_axi_araddr;
            arid_q   <= s_axi_arid;
            rdata_q  <= sel_data;
            rresp_q  <= sel_resp;
        end else if ((state == RD_WAIT_RX) && rx_valid) begin
            rdata_q <= axi_data_t'(rx_byte);  // Late byte arrival
            rresp_q <= `RESP_OKAY;
        end
    end

endmodule

// File: hw/axi_uart_bridge.sv
`timescale 1ns/1ps

module axi_uart_bridge
    import axi_uart_bridge_pkg::*;
(
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    // AXI write address
    input  axi_addr_t  s_axi_awaddr,
    input  axi_id_t    s_axi_awid,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    // AXI write data
    input  axi_data_t  s_axi_wdata,
    input  logic       s_axi_wvalid,
    input  logic       s_axi_wlast,
    output logic       s_axi_wready,
    // AXI write response
    output axi_id_t    s_axi_bid,
    output axi_resp_t  s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    // AXI read address
    input  axi_addr_t  s_axi_araddr,
    input  axi_id_t    s_axi_arid,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    // AXI read data
    output axi_data_t  s_axi_rdata,
    output axi_id_t    s_axi_rid,
    output axi_resp_t  s_axi_rresp,
    output logic       s_axi_rvalid,
    output logic       s_axi_rlast,
    input  logic       s_axi_rready,
    // UART
    output logic       tx_start,
    output uart_byte_t tx_data,
    input  logic       tx_busy,
    input  logic       rx_ready,
    input  uart_byte_t rx_data,
    // CameraLink
    output cam_ctrl_t  cam_ctrl,
    input  logic       clink_ready
);

    uart_byte_t rx_byte;   // Held byte
    logic       rx_valid;
    logic       rx_clear;  // Read side consumed the byte

    //////////////////////////////
    // Write path
    //////////////////////////////
    axi_write_ctrl u_write_ctrl (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awid    (s_axi_awid),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wlast   (s_axi_wlast),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bid     (s_axi_bid),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .tx_start      (tx_start),
        .tx_data       (tx_data),
        .tx_busy       (tx_busy),
        .cam_ctrl      (cam_ctrl)
    );

    //////////////////////////////
    // Read path
    //////////////////////////////
    axi_read_ctrl u_read_ctrl (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arid    (s_axi_arid),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rid     (s_axi_rid),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rlast   (s_axi_rlast),
        .s_axi_rready  (s_axi_rready),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .rx_clear      (rx_clear),
        .clink_ready   (clink_ready)
    );

    uart_rx_buffer u_rx_buffer (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .rx_ready      (rx_ready),
        .rx_data       (rx_data),
        .rx_clear      (rx_clear),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid)
    );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic s_axi_aclk,
    output logic s_axi_aresetn
);

    initial begin
        s_axi_aclk = 1'b0;
        forever #20 s_axi_aclk = ~s_axi_aclk;  // 40 ns period
    end

    // Reset held over the first three rising edges
    initial begin
        s_axi_aresetn = 1'b0;
        repeat (3) @(posedge s_axi_aclk);
        #5 s_axi_aresetn = 1'b1;
    end

endmodule

// File: verif/axi_uart_bridge_props.sv
`timescale 1ns/1ps

module axi_uart_bridge_props
    import axi_uart_bridge_pkg::*;
(
    input logic      s_axi_aclk,
    input logic      s_axi_aresetn,
    input logic      resp_valid,   // bvalid or rvalid
    input logic      resp_ready,
    input axi_data_t resp_data,
    input axi_id_t   resp_id,
    input axi_resp_t resp_code,
    input logic      resp_last,
    input logic      tx_start,
    input logic      tx_busy
);

    //////////////////////////////
    // Response channel rules
    //////////////////////////////
    hold_resp: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data)
            && $stable(resp_id) && $stable(resp_code))
        else $error("response dropped or changed before ready");

    last_matches_valid: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        resp_last == resp_valid)
        else $error("last flag differs from valid");

    //////////////////////////////
    // UART transmit rules
    //////////////////////////////
    tx_single_cycle: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        tx_start |=> !tx_start)
        else $error("tx_start longer than one cycle");

    tx_not_busy: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        $rose(tx_start) |-> !tx_busy)
        else $error("tx_start raised while UART busy");

endmodule

// Write side, no data on B so last follows valid
bind axi_write_ctrl axi_uart_bridge_props u_write_props (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .resp_valid    (s_axi_bvalid),
    .resp_ready    (s_axi_bready),
    .resp_data     ('0),
    .resp_id       (s_axi_bid),
    .resp_code     (s_axi_bresp),
    .resp_last     (s_axi_bvalid),
    .tx_start      (tx_start),
    .tx_busy       (tx_busy)
);

bind axi_read_ctrl axi_uart_bridge_props u_read_props (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .resp_valid    (s_axi_rvalid),
    .resp_ready    (s_axi_rready),
    .resp_data     (s_axi_rdata),
    .resp_id       (s_axi_rid),
    .resp_code     (s_axi_rresp),
    .resp_last     (s_axi_rlast),
    .tx_start      (1'b0),  // No UART on this side
    .tx_busy       (1'b0)
);

// File: verif/axi_uart_bridge_tb.sv
`timescale 1ns/1ps
`include "axi_uart_bridge_config.svh"

module axi_uart_bridge_tb
    import axi_uart_bridge_pkg::*;
();

    localparam int N_RANDOM      = 60;
    localparam int N_DIRECTED    = 5;
    localparam int CLK_PERIOD_NS = 40;
    localparam int WATCHDOG_NS   = (N_RANDOM + N_DIRECTED) * 200 * CLK_PERIOD_NS;

    logic       s_axi_aclk;
    logic       s_axi_aresetn;
    axi_addr_t  s_axi_awaddr;
    axi_id_t    s_axi_awid;
    logic       s_axi_awvalid;
    logic       s_axi_awready;
    axi_data_t  s_axi_wdata;
    logic       s_axi_wvalid;
    logic       s_axi_wlast;
    logic       s_axi_wready;
    axi_id_t    s_axi_bid;
    axi_resp_t  s_axi_bresp;
    logic       s_axi_bvalid;
    logic       s_axi_bready;
    axi_addr_t  s_axi_araddr;
    axi_id_t    s_axi_arid;
    logic       s_axi_arvalid;
    logic       s_axi_arready;
    axi_data_t  s_axi_rdata;
    axi_id_t    s_axi_rid;
    axi_resp_t  s_axi_rresp;
    logic       s_axi_rvalid;
    logic       s_axi_rlast;
    logic       s_axi_rready;
    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx_busy;
    logic       rx_ready;
    uart_byte_t rx_data;
    cam_ctrl_t  cam_ctrl;
    logic       clink_ready;

    // Reference model
    uart_byte_t tx_expect[$];   // Bytes owed to the UART, in order
    cam_ctrl_t  exp_cam;
    logic       exp_rx_valid;
    uart_byte_t exp_rx_byte;
    logic [31:0] lfsr;

    tb_clock_gen u_clock_gen (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn)
    );

    axi_uart_bridge dut (.*);

    //////////////////////////////
    // Reporting and compares
    //////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compare_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s got %0h, expected %0h", $time, name, got, exp));
    endtask

    task automatic compare_cam(input string name, input cam_ctrl_t got, input cam_ctrl_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s got %0h, expected %0h", $time, name, got, exp));
    endtask

    task automatic compare_data(input string name, input axi_data_t got, input axi_data_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s got %0h, expected %0h", $time, name, got, exp));
    endtask

    task automatic compare_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s got %0h, expected %0h", $time, name, got, exp));
    endtask

    task automatic compare_id(input string name, input axi_id_t got, input axi_id_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s got %0h, expected %0h", $time, name, got, exp));
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s got %0b, expected %0b", $time, name, got, exp));
    endtask

    //////////////////////////////
    // Random source
    //////////////////////////////
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // Galois step
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic axi_data_t rand_data();
        return {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
    endfunction

    //////////////////////////////
    // UART and bus models
    //////////////////////////////
    initial begin : uart_model
        int busy_len;
        tx_busy = 1'b0;
        forever begin
            @(negedge s_axi_aclk);
            if (tx_start) begin
                if (tx_expect.size() == 0)
                    abort_run("tx_start was issued with no byte pending");
                compare_byte("tx_data", tx_data, tx_expect.pop_front());
                busy_len = 1 + int'(rand_bits(2));  // 1 to 4 cycles
                @(posedge s_axi_aclk);
                #5 tx_busy = 1'b1;
                repeat (busy_len) begin
                    @(negedge s_axi_aclk);
                    if (tx_start)
                        abort_run("tx_start was issued while the UART was busy");
                    @(posedge s_axi_aclk);
                end
                #5 tx_busy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("Watchdog expired, the bus stopped making progress");
    end

    task automatic strobe_rx(input uart_byte_t b);
        rx_ready = 1'b1;
        rx_data  = b;
        @(posedge s_axi_aclk);
        #5 rx_ready = 1'b0;
        exp_rx_valid = 1'b1;  // Newest byte overwrites
        exp_rx_byte  = b;
    endtask

    task automatic run_write(input axi_addr_t addr, input axi_id_t id, input int beats);
        axi_data_t beat;
        axi_resp_t exp_resp;
        int stall;
        int i;
        s_axi_awaddr  = addr;
        s_axi_awid    = id;
        s_axi_awvalid = 1'b1;
        @(negedge s_axi_aclk);
        while (!s_axi_awready) @(negedge s_axi_aclk);
        @(posedge s_axi_aclk);
        #5 s_axi_awvalid = 1'b0;
        exp_resp = ((addr == `ADDR_UART_TX) || (addr == `ADDR_CAM_CTRL)) ? `RESP_OKAY
                                                                          : `RESP_SLVERR;
        for (i = 0; i < beats; i++) begin
            beat         = rand_data();
            s_axi_wdata  = beat;
            s_axi_wlast  = (i == beats - 1);
            s_axi_wvalid = 1'b1;
            @(negedge s_axi_aclk);
            while (!s_axi_wready) @(negedge s_axi_aclk);  // Beat moves on the next edge
            if (addr == `ADDR_UART_TX) tx_expect.push_back(beat[7:0]);
            else if (addr == `ADDR_CAM_CTRL) exp_cam = beat[3:0];
            @(posedge s_axi_aclk);
            #5;
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;
        stall = int'(rand_bits(2));
        s_axi_bready = (stall == 0);
        @(negedge s_axi_aclk);
        while (!s_axi_bvalid) @(negedge s_axi_aclk);
        if (stall != 0) begin
            repeat (stall) @(posedge s_axi_aclk);
            #5 s_axi_bready = 1'b1;
            @(negedge s_axi_aclk);
        end
        compare_flag("s_axi_bvalid", s_axi_bvalid, 1'b1);
        compare_id("s_axi_bid", s_axi_bid, id);
        compare_resp("s_axi_bresp", s_axi_bresp, exp_resp);
        @(posedge s_axi_aclk);
        #5 s_axi_bready = 1'b0;
        compare_flag("s_axi_bvalid", s_axi_bvalid, 1'b0);  // Accepted, not offered again
        if (tx_expect.size() != 0)
            abort_run("UART bytes were still missing after the write response");
        compare_cam("cam_ctrl", cam_ctrl, exp_cam);
    endtask

    task automatic run_read(input axi_addr_t addr, input axi_id_t id);
        axi_data_t  exp_data;
        axi_resp_t  exp_resp;
        uart_byte_t late_byte;
        logic       wait_byte;
        int         stall;
        s_axi_araddr  = addr;
        s_axi_arid    = id;
        s_axi_arvalid = 1'b1;
        @(negedge s_axi_aclk);
        while (!s_axi_arready) @(negedge s_axi_aclk);
        exp_resp  = `RESP_OKAY;
        wait_byte = 1'b0;
        case (addr)  // Register map, zero-extended
            `ADDR_UART_RX: begin
                exp_data  = axi_data_t'(exp_rx_byte);
                wait_byte = !exp_rx_valid;
            end
            `ADDR_RX_VALID:    exp_data = axi_data_t'(exp_rx_valid);
            `ADDR_CLINK_READY: exp_data = axi_data_t'(clink_ready);
            default: begin
                exp_data = '0;
                exp_resp = `RESP_SLVERR;
            end
        endcase
        @(posedge s_axi_aclk);
        #5 s_axi_arvalid = 1'b0;
        if (wait_byte) begin
            repeat (1 + int'(rand_bits(3))) @(posedge s_axi_aclk);  // Read parks meanwhile
            #5;
            late_byte = uart_byte_t'(rand_bits(8));
            strobe_rx(late_byte);
            exp_data = axi_data_t'(late_byte);
        end
        stall = int'(rand_bits(2));
        s_axi_rready = (stall == 0);
        @(negedge s_axi_aclk);
        while (!s_axi_rvalid) @(negedge s_axi_aclk);
        if (stall != 0) begin
            repeat (stall) @(posedge s_axi_aclk);
            #5 s_axi_rready = 1'b1;
            @(negedge s_axi_aclk);
        end
        compare_flag("s_axi_rvalid", s_axi_rvalid, 1'b1);
        compare_flag("s_axi_rlast", s_axi_rlast, 1'b1);
        compare_id("s_axi_rid", s_axi_rid, id);
        compare_resp("s_axi_rresp", s_axi_rresp, exp_resp);
        compare_data("s_axi_rdata", s_axi_rdata, exp_data);
        @(posedge s_axi_aclk);
        #5 s_axi_rready = 1'b0;
        compare_flag("s_axi_rvalid", s_axi_rvalid, 1'b0);  // Accepted, not offered again
        if (addr == `ADDR_UART_RX) exp_rx_valid = 1'b0;  // Byte consumed
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin : stimulus
        axi_addr_t addr;
        axi_id_t   id;
        int        sel;
        int        n;
        lfsr          = 32'hc2d0;
        s_axi_awaddr  = '0;
        s_axi_awid    = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_wlast   = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arid    = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        rx_ready      = 1'b0;
        rx_data       = '0;
        clink_ready   = 1'b0;
        exp_cam       = '0;
        exp_rx_valid  = 1'b0;
        exp_rx_byte   = '0;
        @(posedge s_axi_aresetn);
        @(posedge s_axi_aclk);
        #5;
        compare_flag("s_axi_bvalid", s_axi_bvalid, 1'b0);  // Reset state
        compare_flag("s_axi_rvalid", s_axi_rvalid, 1'b0);
        compare_flag("tx_start", tx_start, 1'b0);
        compare_flag("s_axi_awready", s_axi_awready, 1'b1);
        compare_flag("s_axi_wready", s_axi_wready, 1'b0);
        compare_flag("s_axi_arready", s_axi_arready, 1'b1);
        compare_cam("cam_ctrl", cam_ctrl, '0);

        // Receive path, flag then byte then flag again
        run_read(`ADDR_UART_RX, axi_id_t'(rand_bits(16)));  // Empty buffer, read waits
        strobe_rx(uart_byte_t'(rand_bits(8)));
        strobe_rx(uart_byte_t'(rand_bits(8)));
        run_read(`ADDR_RX_VALID, axi_id_t'(rand_bits(16)));
        run_read(`ADDR_UART_RX, axi_id_t'(rand_bits(16)));
        run_read(`ADDR_RX_VALID, axi_id_t'(rand_bits(16)));
        run_read(`ADDR_CLINK_READY, axi_id_t'(rand_bits(16)));

        for (n = 0; n < N_RANDOM; n++) begin
            if (rand_bits(2) == 32'd0) strobe_rx(uart_byte_t'(rand_bits(8)));
            if (rand_bits(2) == 32'd0) clink_ready = 1'(rand_bits(1));
            id  = axi_id_t'(rand_bits(16));
            sel = int'(rand_bits(2));
            if (rand_bits(1) == 32'd1) begin
                if (sel == 0) addr = `ADDR_UART_TX;
                else if (sel == 1) addr = `ADDR_CAM_CTRL;
                else addr = axi_addr_t'(rand_bits(7));  // Mostly unmapped
                run_write(addr, id, 1 + int'(rand_bits(2)));
            end else begin
                if (sel == 0) addr = `ADDR_UART_RX;
                else if (sel == 1) addr = `ADDR_RX_VALID;
                else if (sel == 2) addr = `ADDR_CLINK_READY;
                else addr = axi_addr_t'(rand_bits(7));
                run_read(addr, id);
            end
        end

        repeat (4) @(posedge s_axi_aclk);
        $display("test passed");
        $finish;
    end

endmodule

// File: axi_uart_bridge.f
+incdir+hw
hw/axi_uart_bridge_pkg.sv
hw/uart_rx_buffer.sv
hw/axi_write_ctrl.sv
hw/axi_read_ctrl.sv
hw/axi_uart_bridge.sv
verif/tb_clock_gen.sv
verif/axi_uart_bridge_props.sv
verif/axi_uart_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI UART bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module axi_uart_bridge_tb \
    -f axi_uart_bridge.f \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
